// ==== source/rs_defines.svh ====
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// One station entry per functional unit
`define RS_NUM_FU 4

// Physical register tags
`define RS_NUM_PR 32

// ROB depth sets the rollback wrap
`define RS_NUM_ROB 16

// Operand width
`define RS_DATA_W 32

// Derived index widths
`define RS_FU_W $clog2(`RS_NUM_FU)
`define RS_TAG_W $clog2(`RS_NUM_PR)
`define RS_ROB_W $clog2(`RS_NUM_ROB)

`endif

// ==== source/rs_pkg.sv ====
`default_nettype none

`include "rs_defines.svh"

package rs_pkg;

  typedef logic [`RS_FU_W-1:0] fu_idx_t;
  typedef logic [`RS_TAG_W-1:0] tag_t;
  typedef logic [`RS_ROB_W-1:0] rob_idx_t;
  typedef logic [`RS_DATA_W-1:0] data_t;

  typedef enum logic [1:0] {
    FU_ALU    = 2'd0,
    FU_MUL    = 2'd1,
    FU_MEM    = 2'd2,
    FU_BRANCH = 2'd3
  } fu_kind_e;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_MUL  = 4'd4,
    OP_LOAD = 4'd5,
    OP_BEQ  = 4'd6
  } fu_op_e;

  // Kind served by each station entry with index 0 on the right
  localparam fu_kind_e [`RS_NUM_FU-1:0] fu_list = '{FU_MEM, FU_MUL, FU_ALU, FU_ALU};

  typedef struct packed {
    tag_t tag;
    logic ready;
  } src_t;

  typedef struct packed {
    fu_op_e   op;
    fu_kind_e kind;
    tag_t     dest_tag;
    rob_idx_t rob_idx;
    tag_t     src1_tag;
    tag_t     src2_tag;
  } dispatch_t;

  typedef struct packed {
    logic     busy;
    fu_op_e   op;
    tag_t     dest_tag;
    rob_idx_t rob_idx;
    src_t     src1;
    src_t     src2;
  } rs_entry_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t value;
  } cdb_t;

  // Squash window runs from base up to base + count and wraps
  typedef struct packed {
    logic     valid;
    rob_idx_t base;
    rob_idx_t count;
  } rollback_t;

  typedef struct packed {
    logic     valid;
    fu_op_e   op;
    tag_t     dest_tag;
    rob_idx_t rob_idx;
    data_t    operand_a;
    data_t    operand_b;
  } issue_t;

  typedef issue_t [`RS_NUM_FU-1:0] issue_vec_t;
  typedef rs_entry_t [`RS_NUM_FU-1:0] rs_entry_vec_t;
  typedef tag_t [`RS_NUM_FU-1:0] tag_vec_t;
  typedef data_t [`RS_NUM_FU-1:0] data_vec_t;

endpackage

`default_nettype wire

// ==== source/rs_station.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module rs_station (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  dispatch_valid,
  input  rs_pkg::dispatch_t          dispatch,
  input  wire logic                  src1_ready,      // From operand file with CDB bypass
  input  wire logic                  src2_ready,
  input  rs_pkg::cdb_t               cdb,
  input  rs_pkg::rollback_t          rollback,
  input  wire logic [`RS_NUM_FU-1:0] fu_ready,
  output rs_pkg::rs_entry_vec_t      entries,         // After wakeup
  output logic      [`RS_NUM_FU-1:0] request,
  output logic                       dispatch_accept,
  output logic                       dispatch_stall
);

  rs_pkg::rs_entry_vec_t                    rs_q;
  rs_pkg::rs_entry_vec_t                    rs_d;
  rs_pkg::rs_entry_vec_t                    woken;
  rs_pkg::rob_idx_t      [`RS_NUM_FU-1:0]   rob_diff;
  logic                  [`RS_NUM_FU-1:0]   src1_cdb;
  logic                  [`RS_NUM_FU-1:0]   src2_cdb;
  logic                  [`RS_NUM_FU-1:0]   squash;
  logic                  [`RS_NUM_FU-1:0]   issuing;
  logic                  [`RS_NUM_FU-1:0]   free;
  logic                                     match_hit;
  rs_pkg::fu_idx_t                          match_idx;

  // CDB wakeup and rollback window per entry
  always_comb begin
    for (int i = 0; i < `RS_NUM_FU; i++) begin
      src1_cdb[i] = cdb.valid && (rs_q[i].src1.tag == cdb.tag);
      src2_cdb[i] = cdb.valid && (rs_q[i].src2.tag == cdb.tag);
      woken[i] = rs_q[i];
      woken[i].src1.ready = rs_q[i].src1.ready || src1_cdb[i];
      woken[i].src2.ready = rs_q[i].src2.ready || src2_cdb[i];
      rob_diff[i] = rs_q[i].rob_idx - rollback.base;   // Wraps modulo ROB depth
      squash[i] = rollback.valid && rs_q[i].busy && (rob_diff[i] <= rollback.count);
    end
  end

  assign entries = woken;

  // Requests and entries that leave this cycle
  always_comb begin
    for (int i = 0; i < `RS_NUM_FU; i++) begin
      request[i] = woken[i].busy && woken[i].src1.ready && woken[i].src2.ready
                   && !squash[i];
      issuing[i] = request[i] && fu_ready[i];
      // A squashed slot sits out this cycle's dispatch
      free[i] = !squash[i] && (!rs_q[i].busy || issuing[i]);
    end
  end

  // Lowest free entry of the right kind
  always_comb begin
    match_hit = 1'b0;
    match_idx = '0;
    for (int i = `RS_NUM_FU - 1; i >= 0; i--) begin
      if (free[i] && (rs_pkg::fu_list[i] == dispatch.kind)) begin
        match_hit = 1'b1;
        match_idx = rs_pkg::fu_idx_t'(i);
      end
    end
  end

  assign dispatch_accept = dispatch_valid && match_hit;
  assign dispatch_stall  = dispatch_valid && !match_hit;

  // Clear on issue or squash first, then allocate
  always_comb begin
    rs_d = woken;
    for (int i = 0; i < `RS_NUM_FU; i++) begin
      if (issuing[i] || squash[i]) begin
        rs_d[i] = '0;
      end
    end
    if (dispatch_accept) begin
      rs_d[match_idx].busy       = 1'b1;
      rs_d[match_idx].op         = dispatch.op;
      rs_d[match_idx].dest_tag   = dispatch.dest_tag;
      rs_d[match_idx].rob_idx    = dispatch.rob_idx;
      rs_d[match_idx].src1.tag   = dispatch.src1_tag;
      rs_d[match_idx].src1.ready = src1_ready;   // Looked up at dispatch
      rs_d[match_idx].src2.tag   = dispatch.src2_tag;
      rs_d[match_idx].src2.ready = src2_ready;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RS_NUM_FU; i++) begin
        rs_q[i].busy <= 1'b0;   // Payload left as is
      end
    end else begin
      rs_q <= rs_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/operand_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module operand_file (
  input  wire logic         clock,
  input  wire logic         reset,
  input  rs_pkg::cdb_t      cdb,
  input  wire logic         alloc_valid,    // Accepted dispatch
  input  rs_pkg::tag_t      alloc_tag,
  input  rs_pkg::tag_t      disp_tag1,
  input  rs_pkg::tag_t      disp_tag2,
  input  rs_pkg::tag_vec_t  read_tag_a,
  input  rs_pkg::tag_vec_t  read_tag_b,
  output logic              disp_ready1,
  output logic              disp_ready2,
  output rs_pkg::data_vec_t read_value_a,
  output rs_pkg::data_vec_t read_value_b
);

  rs_pkg::data_t               value_q [`RS_NUM_PR];
  logic        [`RS_NUM_PR-1:0] ready_q;

  // Register value with the CDB result forwarded
  function automatic rs_pkg::data_t bypass_value(input rs_pkg::tag_t tag);
    rs_pkg::data_t result;
    result = value_q[tag];
    if (cdb.valid && (cdb.tag == tag)) begin
      result = cdb.value;
    end
    return result;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RS_NUM_PR; i++) begin
        value_q[i] <= '0;
      end
      ready_q <= '1;   // Every tag starts ready at zero
    end else begin
      if (cdb.valid) begin
        value_q[cdb.tag] <= cdb.value;
        ready_q[cdb.tag] <= 1'b1;
      end
      if (alloc_valid) begin
        ready_q[alloc_tag] <= 1'b0;   // New producer wins
      end
    end
  end

  assign disp_ready1 = ready_q[disp_tag1] || (cdb.valid && (cdb.tag == disp_tag1));
  assign disp_ready2 = ready_q[disp_tag2] || (cdb.valid && (cdb.tag == disp_tag2));

  always_comb begin
    for (int i = 0; i < `RS_NUM_FU; i++) begin
      read_value_a[i] = bypass_value(read_tag_a[i]);
      read_value_b[i] = bypass_value(read_tag_b[i]);
    end
  end

endmodule

`default_nettype wire

// ==== source/issue_assembler.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module issue_assembler (
  input  rs_pkg::rs_entry_vec_t      entries,
  input  wire logic [`RS_NUM_FU-1:0] request,
  input  rs_pkg::data_vec_t          value_a,
  input  rs_pkg::data_vec_t          value_b,
  output rs_pkg::issue_vec_t         issue,
  output rs_pkg::tag_vec_t           read_tag_a,
  output rs_pkg::tag_vec_t           read_tag_b
);

  // Read ports follow the entry sources
  always_comb begin
    for (int i = 0; i < `RS_NUM_FU; i++) begin
      read_tag_a[i] = entries[i].src1.tag;
      read_tag_b[i] = entries[i].src2.tag;
    end
  end

  // Idle slots go out as all zero
  always_comb begin
    for (int i = 0; i < `RS_NUM_FU; i++) begin
      issue[i] = '0;
      if (request[i]) begin
        issue[i].valid     = 1'b1;
        issue[i].op        = entries[i].op;
        issue[i].dest_tag  = entries[i].dest_tag;
        issue[i].rob_idx   = entries[i].rob_idx;
        issue[i].operand_a = value_a[i];   // Already CDB bypassed
        issue[i].operand_b = value_b[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dispatch_issue_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module dispatch_issue_top (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  dispatch_valid,
  input  rs_pkg::dispatch_t          dispatch,
  input  rs_pkg::cdb_t               cdb,
  input  rs_pkg::rollback_t          rollback,
  input  wire logic [`RS_NUM_FU-1:0] fu_ready,
  output rs_pkg::issue_vec_t         issue,
  output logic                       dispatch_stall
);

  rs_pkg::rs_entry_vec_t      entries;
  logic     [`RS_NUM_FU-1:0]  request;
  logic                       dispatch_accept;
  logic                       src1_ready;
  logic                       src2_ready;
  rs_pkg::tag_vec_t           read_tag_a;
  rs_pkg::tag_vec_t           read_tag_b;
  rs_pkg::data_vec_t          read_value_a;
  rs_pkg::data_vec_t          read_value_b;

  rs_station rs_station_i (
    .clock           (clock),
    .reset           (reset),
    .dispatch_valid  (dispatch_valid),
    .dispatch        (dispatch),
    .src1_ready      (src1_ready),
    .src2_ready      (src2_ready),
    .cdb             (cdb),
    .rollback        (rollback),
    .fu_ready        (fu_ready),
    .entries         (entries),
    .request         (request),
    .dispatch_accept (dispatch_accept),
    .dispatch_stall  (dispatch_stall)
  );

  operand_file operand_file_i (
    .clock        (clock),
    .reset        (reset),
    .cdb          (cdb),
    .alloc_valid  (dispatch_accept),
    .alloc_tag    (dispatch.dest_tag),
    .disp_tag1    (dispatch.src1_tag),
    .disp_tag2    (dispatch.src2_tag),
    .read_tag_a   (read_tag_a),
    .read_tag_b   (read_tag_b),
    .disp_ready1  (src1_ready),
    .disp_ready2  (src2_ready),
    .read_value_a (read_value_a),
    .read_value_b (read_value_b)
  );

  issue_assembler issue_assembler_i (
    .entries    (entries),
    .request    (request),
    .value_a    (read_value_a),
    .value_b    (read_value_b),
    .issue      (issue),
    .read_tag_a (read_tag_a),
    .read_tag_b (read_tag_b)
  );

endmodule

`default_nettype wire

// ==== bench/dispatch_issue_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module dispatch_issue_chk (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  rs_pkg::dispatch_t          dispatch,
  input  rs_pkg::rs_entry_vec_t      entries,
  input  wire logic [`RS_NUM_FU-1:0] request,
  input  wire logic [`RS_NUM_FU-1:0] fu_ready,
  input  rs_pkg::rollback_t          rollback,
  input  wire logic                  dispatch_accept,
  input  wire logic                  dispatch_stall
);

  int failures = 0;   // Failed assertions so far

  // True when some idle slot serves this kind
  function automatic logic idle_slot(input rs_pkg::rs_entry_vec_t slots,
                                     input rs_pkg::fu_kind_e kind);
    logic found;
    found = 1'b0;
    for (int i = 0; i < `RS_NUM_FU; i++) begin
      if (!slots[i].busy && (rs_pkg::fu_list[i] == kind)) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // A stalled dispatch is not taken and finds every slot of its kind busy
  accept_or_stall: assert property (@(posedge clock) disable iff (reset)
    dispatch_stall |-> (!dispatch_accept && !idle_slot(entries, dispatch.kind)))
    else begin
      failures++;
      $error("dispatch stalled beside an idle slot of its kind");
    end

  // Nothing issues in the cycle after a reset edge
  quiet_after_reset: assert property (@(posedge clock) reset |=> (request == '0))
    else begin
      failures++;
      $error("issue request raised after reset");
    end

  for (genvar i = 0; i < `RS_NUM_FU; i++) begin : g_entry
    // Issued slot with no new dispatch goes idle and quiet
    busy_request: assert property (@(posedge clock) disable iff (reset)
      (request[i] && fu_ready[i] && !dispatch_accept) |=> (!entries[i].busy && !request[i]))
      else begin
        failures++;
        $error("request from idle entry %0d", i);
      end

    // Back-pressured entry keeps its packet unless squashed
    held_stable: assert property (@(posedge clock) disable iff (reset)
      (request[i] && !fu_ready[i] && !rollback.valid) |=>
        (rollback.valid || (request[i] && $stable(entries[i]))))
      else begin
        failures++;
        $error("held issue on entry %0d changed", i);
      end
  end

endmodule

bind rs_station dispatch_issue_chk dispatch_issue_chk_i (
  .clock           (clock),
  .reset           (reset),
  .dispatch        (dispatch),
  .entries         (entries),
  .request         (request),
  .fu_ready        (fu_ready),
  .rollback        (rollback),
  .dispatch_accept (dispatch_accept),
  .dispatch_stall  (dispatch_stall)
);

`default_nettype wire

// ==== bench/dispatch_issue_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module dispatch_issue_tb;

  typedef struct packed {
    logic              dispatch_valid;
    rs_pkg::dispatch_t dispatch;
    rs_pkg::cdb_t      cdb;
    rs_pkg::rollback_t rollback;
  } stim_t;

  typedef struct {
    string                 name;
    stim_t                 stim;
    logic [`RS_NUM_FU-1:0] fu_ready;
    int                    check_idx;   // Slot compared this step
    rs_pkg::issue_t        exp_issue;
    logic                  exp_stall;
  } step_t;

  logic                  clock;
  logic                  reset;
  logic                  dispatch_valid;
  rs_pkg::dispatch_t     dispatch;
  rs_pkg::cdb_t          cdb;
  rs_pkg::rollback_t     rollback;
  logic [`RS_NUM_FU-1:0] fu_ready;
  rs_pkg::issue_vec_t    issue;
  logic                  dispatch_stall;

  step_t steps[$];
  int    error_count = 0;
  int    check_count = 0;

  dispatch_issue_top dispatch_issue_top_i (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .cdb            (cdb),
    .rollback       (rollback),
    .fu_ready       (fu_ready),
    .issue          (issue),
    .dispatch_stall (dispatch_stall)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Unit kind that serves each opcode
  function automatic rs_pkg::fu_kind_e kind_of(rs_pkg::fu_op_e op);
    rs_pkg::fu_kind_e kind;
    case (op)
      rs_pkg::OP_MUL:  kind = rs_pkg::FU_MUL;
      rs_pkg::OP_LOAD: kind = rs_pkg::FU_MEM;
      rs_pkg::OP_BEQ:  kind = rs_pkg::FU_BRANCH;
      default:         kind = rs_pkg::FU_ALU;
    endcase
    return kind;
  endfunction

  function automatic stim_t quiet();
    return '0;
  endfunction

  function automatic stim_t send(rs_pkg::fu_op_e op, int dest, int rob, int src1, int src2);
    stim_t s;
    s = '0;
    s.dispatch_valid    = 1'b1;
    s.dispatch.op       = op;
    s.dispatch.kind     = kind_of(op);
    s.dispatch.dest_tag = rs_pkg::tag_t'(dest);
    s.dispatch.rob_idx  = rs_pkg::rob_idx_t'(rob);
    s.dispatch.src1_tag = rs_pkg::tag_t'(src1);
    s.dispatch.src2_tag = rs_pkg::tag_t'(src2);
    return s;
  endfunction

  function automatic stim_t broadcast(stim_t s, int tag, rs_pkg::data_t value);
    s.cdb.valid = 1'b1;
    s.cdb.tag   = rs_pkg::tag_t'(tag);
    s.cdb.value = value;
    return s;
  endfunction

  function automatic stim_t squash(stim_t s, int base, int count);
    s.rollback.valid = 1'b1;
    s.rollback.base  = rs_pkg::rob_idx_t'(base);
    s.rollback.count = rs_pkg::rob_idx_t'(count);
    return s;
  endfunction

  function automatic rs_pkg::issue_t issue_of(rs_pkg::fu_op_e op, int dest, int rob,
                                              rs_pkg::data_t a, rs_pkg::data_t b);
    rs_pkg::issue_t e;
    e.valid     = 1'b1;
    e.op        = op;
    e.dest_tag  = rs_pkg::tag_t'(dest);
    e.rob_idx   = rs_pkg::rob_idx_t'(rob);
    e.operand_a = a;
    e.operand_b = b;
    return e;
  endfunction

  function automatic string issue_text(rs_pkg::issue_t p);
    return $sformatf("v=%0b op=%0d dest=%0d rob=%0d a=%h b=%h", p.valid, p.op,
                     p.dest_tag, p.rob_idx, p.operand_a, p.operand_b);
  endfunction

  task automatic table_row(input string name, input stim_t stim,
                           input logic [`RS_NUM_FU-1:0] ready, input int idx,
                           input rs_pkg::issue_t exp_issue, input logic exp_stall);
    step_t row;
    row.name      = name;
    row.stim      = stim;
    row.fu_ready  = ready;
    row.check_idx = idx;
    row.exp_issue = exp_issue;
    row.exp_stall = exp_stall;
    steps.push_back(row);
  endtask

  task automatic check_issue(input string name, input rs_pkg::issue_t expected,
                             input rs_pkg::issue_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error %s: issue expected %s, actual %s", name,
               issue_text(expected), issue_text(actual));
    end
  endtask

  task automatic check_stall(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error %s: dispatch_stall expected %b, actual %b", name, expected, actual);
    end
  endtask

  initial begin : watchdog
    for (int c = 0; c < 200; c++) @(posedge clock);
    $display("Timeout: simulation ran past 200 clock cycles");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset          <= 1'b1;
    dispatch_valid <= 1'b0;
    dispatch       <= '0;
    cdb            <= '0;
    rollback       <= '0;
    fu_ready       <= '1;

    // Seed tags 1 and 2 before an ADD that is ready at dispatch
    table_row("cdb_t1", broadcast(quiet(), 1, 'h11), 4'hf, 0, '0, 1'b0);
    table_row("cdb_t2", broadcast(quiet(), 2, 'h22), 4'hf, 0, '0, 1'b0);
    table_row("add_disp", send(rs_pkg::OP_ADD, 3, 1, 1, 2), 4'hf, 0, '0, 1'b0);
    table_row("add_issue", quiet(), 4'hf, 0, issue_of(rs_pkg::OP_ADD, 3, 1, 'h11, 'h22), 1'b0);
    // MUL waits on tag 3 and takes its value off the CDB
    table_row("mul_disp", send(rs_pkg::OP_MUL, 4, 2, 3, 1), 4'hf, 2, '0, 1'b0);
    table_row("mul_wait", quiet(), 4'hf, 2, '0, 1'b0);
    table_row("mul_wake", broadcast(quiet(), 3, 'h33), 4'hf, 2,
              issue_of(rs_pkg::OP_MUL, 4, 2, 'h33, 'h11), 1'b0);
    // MUL unit back-pressured for two cycles
    table_row("mul2_disp", send(rs_pkg::OP_MUL, 5, 3, 3, 2), 4'b1011, 2, '0, 1'b0);
    table_row("mul2_hold", quiet(), 4'b1011, 2, issue_of(rs_pkg::OP_MUL, 5, 3, 'h33, 'h22), 1'b0);
    table_row("mul2_held", quiet(), 4'b1011, 2, issue_of(rs_pkg::OP_MUL, 5, 3, 'h33, 'h22), 1'b0);
    table_row("mul3_disp", send(rs_pkg::OP_MUL, 6, 4, 1, 2), 4'hf, 2,
              issue_of(rs_pkg::OP_MUL, 5, 3, 'h33, 'h22), 1'b0);
    table_row("mul3_issue", quiet(), 4'hf, 2, issue_of(rs_pkg::OP_MUL, 6, 4, 'h11, 'h22), 1'b0);
    // Both ALU slots busy so a third ALU op stalls until slot 0 issues
    table_row("alu_a_disp", send(rs_pkg::OP_ADD, 7, 12, 4, 1), 4'hf, 0, '0, 1'b0);
    table_row("alu_b_disp", send(rs_pkg::OP_SUB, 8, 6, 5, 2), 4'hf, 0, '0, 1'b0);
    table_row("alu_c_stall", send(rs_pkg::OP_AND, 9, 7, 6, 1), 4'hf, 1, '0, 1'b1);
    table_row("alu_c_reuse", broadcast(send(rs_pkg::OP_AND, 9, 7, 6, 1), 4, 'h44), 4'hf, 0,
              issue_of(rs_pkg::OP_ADD, 7, 12, 'h44, 'h11), 1'b0);
    // Rollback of ROB 5 to 7 while ROB 8 survives
    table_row("mul4_disp", send(rs_pkg::OP_MUL, 10, 5, 6, 1), 4'hf, 0, '0, 1'b0);
    table_row("load_disp", send(rs_pkg::OP_LOAD, 11, 8, 5, 1), 4'hf, 2, '0, 1'b0);
    table_row("rollback", squash(broadcast(send(rs_pkg::OP_OR, 12, 9, 1, 2), 5, 'h55), 5, 2),
              4'b0111, 1, '0, 1'b1);
    table_row("rb_survivor", send(rs_pkg::OP_OR, 12, 9, 1, 2), 4'hf, 3,
              issue_of(rs_pkg::OP_LOAD, 11, 8, 'h55, 'h11), 1'b0);
    table_row("or_issue", quiet(), 4'hf, 0, issue_of(rs_pkg::OP_OR, 12, 9, 'h11, 'h22), 1'b0);
    table_row("mul5_disp", send(rs_pkg::OP_MUL, 13, 10, 1, 2), 4'hf, 2, '0, 1'b0);
    table_row("mul5_issue", quiet(), 4'hf, 2,
              issue_of(rs_pkg::OP_MUL, 13, 10, 'h11, 'h22), 1'b0);
    table_row("drained", quiet(), 4'hf, 2, '0, 1'b0);

    for (int c = 0; c < 2; c++) @(posedge clock);
    reset <= 1'b0;

    @(negedge clock);
    for (int i = 0; i < `RS_NUM_FU; i++) begin
      check_issue("reset", '0, issue[i]);
    end
    check_stall("reset", 1'b0, dispatch_stall);

    foreach (steps[k]) begin
      @(posedge clock);
      dispatch_valid <= steps[k].stim.dispatch_valid;
      dispatch       <= steps[k].stim.dispatch;
      cdb            <= steps[k].stim.cdb;
      rollback       <= steps[k].stim.rollback;
      fu_ready       <= steps[k].fu_ready;
      @(negedge clock);   // Outputs settled mid-cycle
      check_issue(steps[k].name, steps[k].exp_issue, issue[steps[k].check_idx]);
      check_stall(steps[k].name, steps[k].exp_stall, dispatch_stall);
    end

    error_count += dispatch_issue_top_i.rs_station_i.dispatch_issue_chk_i.failures;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/rs_pkg.sv
source/rs_station.sv
source/operand_file.sv
source/issue_assembler.sv
source/dispatch_issue_top.sv
bench/dispatch_issue_chk.sv
bench/dispatch_issue_tb.sv

// ==== Makefile ====
# Verilator build and run of the dispatch and issue testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module dispatch_issue_tb \
		-f all.f -Mdir obj_dir -o dispatch_issue_sim

run: compile
	./obj_dir/dispatch_issue_sim > run.log 2>&1 || true
	cat run.log
	@if grep -q "TEST FAILED" run.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" run.log; then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf obj_dir run.log
